/* source/alu_pkg.sv */
package alu_pkg;

	// datapath width, one word
	localparam int DATA_W = 24;

	// shift amount comes from the low bits of operand b
	localparam int SHAMT_W = 5;

	// one shift-add iteration per multiplier bit
	localparam int MUL_STEPS = DATA_W;
	localparam int STEP_W = $clog2(MUL_STEPS + 1); // wide enough for MUL_STEPS

	// result side credits
	localparam int RES_CREDIT_MAX = 4; // consumer never grants more than this
	localparam int CREDIT_W = $clog2(RES_CREDIT_MAX + 1);

	// opcodes, same codes as the alu select
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_XOR = 3'd1,
		OP_SUB = 3'd2,
		OP_SLT = 3'd3, // unsigned
		OP_SLL = 3'd4,
		OP_SRL = 3'd5,
		OP_MUL = 3'd6,
		OP_NOP = 3'd7  // zero result, flags low
	} alu_op_e;

	// sequencing states of the control FSM
	typedef enum logic [1:0] {
		S_IDLE = 2'd0, // waiting for an op
		S_MUL  = 2'd1, // shift-add iterations
		S_OUT  = 2'd2  // result held until a credit is there
	} ctrl_state_e;

endpackage

/* source/adder.sv */
`timescale 1ns/1ns
module adder (
	input  logic [alu_pkg::DATA_W-1:0] a,
	input  logic [alu_pkg::DATA_W-1:0] b,
	input  logic                       sub, // 1 = a - b
	output logic [alu_pkg::DATA_W-1:0] sum,
	output logic                       c,   // carry out, no borrow on sub
	output logic                       z,
	output logic                       v,   // signed overflow
	output logic                       n
);
	import alu_pkg::*;

	logic [DATA_W-1:0] b_eff; // b or ~b
	logic [DATA_W:0]   cy;    // ripple carry chain

	assign b_eff = b ^ {DATA_W{sub}};

	// ripple through every bit, carry in is the sub bit
	always_comb begin
		cy[0] = sub;
		for (int i = 0; i < DATA_W; i++) begin
			sum[i]   = a[i] ^ b_eff[i] ^ cy[i];
			cy[i+1] = (a[i] & b_eff[i]) | (cy[i] & (a[i] ^ b_eff[i]));
		end
	end

	assign c = cy[DATA_W];
	assign z = ~|sum;
	assign v = cy[DATA_W] ^ cy[DATA_W-1]; // carry into msb differs from carry out
	assign n = sum[DATA_W-1];

endmodule

/* source/multiplicator.sv */
`timescale 1ns/1ns
module multiplicator (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,  // load multiplier, clear product
	input  logic                       step,   // one shift-add iteration
	input  logic [alu_pkg::DATA_W-1:0] mcand,
	input  logic [alu_pkg::DATA_W-1:0] mplier,
	output logic [alu_pkg::DATA_W-1:0] prod_lo,
	output logic                       hi_nz,  // upper half not zero
	output logic                       z,
	output logic                       n
);
	import alu_pkg::*;

	logic [2*DATA_W-1:0] prod_q;    // partial product
	logic [DATA_W-1:0]   mpl_q;     // multiplier, consumed lsb first
	logic [DATA_W-1:0]   addend;
	logic [DATA_W:0]     upper_sum; // upper half plus addend, with carry

	// multiplicand only added when the current multiplier bit is set
	assign addend = mpl_q[0] ? mcand : '0;

	assign upper_sum = {1'b0, prod_q[2*DATA_W-1:DATA_W]} + {1'b0, addend};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prod_q <= '0;
			mpl_q  <= '0;
		end else if (start) begin
			prod_q <= '0;
			mpl_q  <= mplier;
		end else if (step) begin
			// add into the upper half then shift the whole thing right
			prod_q <= {upper_sum, prod_q[DATA_W-1:1]};
			mpl_q  <= mpl_q >> 1; // next bit to lsb
		end
	end

	// after MUL_STEPS iterations the full product sits in prod_q
	assign prod_lo = prod_q[DATA_W-1:0];
	assign hi_nz   = |prod_q[2*DATA_W-1:DATA_W]; // used as carry and overflow
	assign z       = ~|prod_q[DATA_W-1:0];
	assign n       = prod_q[DATA_W-1];

endmodule

/* source/step_counter.sv */
`timescale 1ns/1ns
module step_counter (
	input  logic clk,
	input  logic rst_n,
	input  logic load, // start of a multiply
	output logic last  // final iteration in progress
);
	import alu_pkg::*;

	logic [STEP_W-1:0] cnt_q;
	logic              armed_q; // set by a load, keeps last low out of reset

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q   <= '0;
			armed_q <= 1'b0;
		end else if (load) begin
			cnt_q   <= STEP_W'(MUL_STEPS - 1);
			armed_q <= 1'b1;
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1; // hold at zero
		end
	end

	assign last = armed_q & (cnt_q == '0);

endmodule

/* source/alu.sv */
`timescale 1ns/1ns
module alu (
	input  alu_pkg::alu_op_e           op,
	input  logic [alu_pkg::DATA_W-1:0] a,
	input  logic [alu_pkg::DATA_W-1:0] b,
	input  logic [alu_pkg::DATA_W-1:0] mul_lo,    // from multiplicator
	input  logic                       mul_hi_nz,
	input  logic                       mul_z,
	input  logic                       mul_n,
	output logic [alu_pkg::DATA_W-1:0] res,
	output logic                       c,
	output logic                       z,
	output logic                       gt,
	output logic                       v,
	output logic                       n
);
	import alu_pkg::*;

	logic [DATA_W-1:0]  add_res, sub_res;
	logic               add_c, add_z, add_v, add_n;
	logic               sub_c, sub_z, sub_v, sub_n;
	logic               sub_gt;
	logic [SHAMT_W-1:0] shamt;
	logic [DATA_W-1:0]  xor_res, slt_res, sll_res, srl_res;

	adder u_add (
		.a   (a),
		.b   (b),
		.sub (1'b0),
		.sum (add_res),
		.c   (add_c),
		.z   (add_z),
		.v   (add_v),
		.n   (add_n)
	);

	adder u_sub (
		.a   (a),
		.b   (b),
		.sub (1'b1),
		.sum (sub_res),
		.c   (sub_c),
		.z   (sub_z),
		.v   (sub_v),
		.n   (sub_n)
	);

	// positive difference, no overflow
	assign sub_gt = ~sub_n & ~sub_v & ~sub_z;

	assign shamt   = b[SHAMT_W-1:0]; // low five bits of b only
	assign xor_res = a ^ b;
	assign slt_res = {{(DATA_W-1){1'b0}}, (a < b)}; // unsigned compare
	assign sll_res = a << shamt;
	assign srl_res = a >> shamt;

	// result and flag select
	always_comb begin
		res = '0;
		c   = 1'b0;
		z   = 1'b0;
		gt  = 1'b0;
		v   = 1'b0;
		n   = 1'b0;
		case (op)
			OP_ADD: begin
				res = add_res;
				c   = add_c;
				z   = add_z;
				v   = add_v;
				n   = add_n;
			end
			OP_XOR: res = xor_res; // logic ops leave flags low
			OP_SUB: begin
				res = sub_res;
				c   = sub_c;
				z   = sub_z;
				gt  = sub_gt; // only op with gt
				v   = sub_v;
				n   = sub_n;
			end
			OP_SLT: res = slt_res;
			OP_SLL: res = sll_res;
			OP_SRL: res = srl_res;
			OP_MUL: begin
				res = mul_lo;
				c   = mul_hi_nz; // product did not fit one word
				z   = mul_z;
				v   = mul_hi_nz;
				n   = mul_n;
			end
			default: res = '0; // OP_NOP
		endcase
	end

endmodule

/* source/alu_ctrl_fsm.sv */
`timescale 1ns/1ns
module alu_ctrl_fsm (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       op_valid,
	input  alu_pkg::alu_op_e           op_code,
	input  logic [alu_pkg::DATA_W-1:0] op_a,
	input  logic [alu_pkg::DATA_W-1:0] op_b,
	input  logic                       res_credit, // one slot per pulse
	input  logic                       cnt_last,
	input  logic [alu_pkg::DATA_W-1:0] alu_res,
	input  logic                       alu_c,
	input  logic                       alu_z,
	input  logic                       alu_gt,
	input  logic                       alu_v,
	input  logic                       alu_n,
	output logic [alu_pkg::DATA_W-1:0] a_q,
	output logic [alu_pkg::DATA_W-1:0] b_q,
	output alu_pkg::alu_op_e           op_q,
	output logic                       cnt_load,
	output logic                       mul_start,
	output logic                       mul_step,
	output logic                       op_credit,  // op credit back to sender
	output logic                       res_valid,
	output logic [alu_pkg::DATA_W-1:0] res_data,
	output logic                       res_c,
	output logic                       res_z,
	output logic                       res_gt,
	output logic                       res_v,
	output logic                       res_n
);
	import alu_pkg::*;

	ctrl_state_e         state_q, state_d;
	logic                res_ld_q; // first cycle in S_OUT, result not yet registered
	logic [CREDIT_W-1:0] credit_q; // result credits held
	logic                accept;
	logic                send;

	assign accept    = (state_q == S_IDLE) & op_valid;
	assign mul_start = accept & (op_code == OP_MUL); // multiplier loads at capture
	assign cnt_load  = mul_start;
	assign mul_step  = (state_q == S_MUL);
	assign send      = (state_q == S_OUT) & (credit_q != '0);

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: if (op_valid) state_d = (op_code == OP_MUL) ? S_MUL : S_OUT;
			S_MUL:  if (cnt_last) state_d = S_OUT; // last step happens this cycle
			S_OUT:  if (send) state_d = S_IDLE;
			default: state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q   <= S_IDLE;
			res_ld_q  <= 1'b0;
			credit_q  <= '0;
			res_valid <= 1'b0;
			op_credit <= 1'b0;
		end else begin
			state_q   <= state_d;
			res_ld_q  <= (state_q != S_OUT) & (state_d == S_OUT);
			// grant and spend in one cycle cancel out
			credit_q  <= credit_q + CREDIT_W'(res_credit) - CREDIT_W'(send);
			res_valid <= send;
			op_credit <= send; // op slot freed with the result
		end
	end

	// operand and result payload
	always_ff @(posedge clk) begin
		if (accept) begin
			a_q  <= op_a;
			b_q  <= op_b;
			op_q <= op_code;
		end
		if (res_ld_q) begin
			res_data <= alu_res;
			res_c    <= alu_c;
			res_z    <= alu_z;
			res_gt   <= alu_gt;
			res_v    <= alu_v;
			res_n    <= alu_n;
		end
	end

endmodule

/* source/alu_exec_top.sv */
`timescale 1ns/1ns
module alu_exec_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       op_valid,
	input  alu_pkg::alu_op_e           op_code,
	input  logic [alu_pkg::DATA_W-1:0] op_a,
	input  logic [alu_pkg::DATA_W-1:0] op_b,
	input  logic                       res_credit,
	output logic                       op_credit,
	output logic                       res_valid,
	output logic [alu_pkg::DATA_W-1:0] res_data,
	output logic                       res_c,
	output logic                       res_z,
	output logic                       res_gt,
	output logic                       res_v,
	output logic                       res_n
);
	import alu_pkg::*;

	logic [DATA_W-1:0] a_q, b_q;
	alu_op_e           op_q;
	logic              cnt_load, cnt_last;
	logic              mul_start, mul_step;
	logic [DATA_W-1:0] mul_lo;
	logic              mul_hi_nz, mul_z, mul_n;
	logic [DATA_W-1:0] alu_res;
	logic              alu_c, alu_z, alu_gt, alu_v, alu_n;

	alu_ctrl_fsm u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.op_valid   (op_valid),
		.op_code    (op_code),
		.op_a       (op_a),
		.op_b       (op_b),
		.res_credit (res_credit),
		.cnt_last   (cnt_last),
		.alu_res    (alu_res),
		.alu_c      (alu_c),
		.alu_z      (alu_z),
		.alu_gt     (alu_gt),
		.alu_v      (alu_v),
		.alu_n      (alu_n),
		.a_q        (a_q),
		.b_q        (b_q),
		.op_q       (op_q),
		.cnt_load   (cnt_load),
		.mul_start  (mul_start),
		.mul_step   (mul_step),
		.op_credit  (op_credit),
		.res_valid  (res_valid),
		.res_data   (res_data),
		.res_c      (res_c),
		.res_z      (res_z),
		.res_gt     (res_gt),
		.res_v      (res_v),
		.res_n      (res_n)
	);

	step_counter u_cnt (
		.clk   (clk),
		.rst_n (rst_n),
		.load  (cnt_load),
		.last  (cnt_last)
	);

	// multiplier loads straight from op_b at capture, operand regs not yet valid
	multiplicator u_mul (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (mul_start),
		.step    (mul_step),
		.mcand   (a_q),
		.mplier  (op_b),
		.prod_lo (mul_lo),
		.hi_nz   (mul_hi_nz),
		.z       (mul_z),
		.n       (mul_n)
	);

	alu u_alu (
		.op        (op_q),
		.a         (a_q),
		.b         (b_q),
		.mul_lo    (mul_lo),
		.mul_hi_nz (mul_hi_nz),
		.mul_z     (mul_z),
		.mul_n     (mul_n),
		.res       (alu_res),
		.c         (alu_c),
		.z         (alu_z),
		.gt        (alu_gt),
		.v         (alu_v),
		.n         (alu_n)
	);

endmodule

/* testbench/tb_clkgen.sv */
`timescale 1ns/1ns
module tb_clkgen (
	output logic clk,
	output logic rst_n
);
	localparam int RST_CYC = 10; // reset length in clock cycles

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (RST_CYC) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1; // released away from the rising edge
	end

endmodule

/* testbench/tb_alu_exec_asserts.sv */
`timescale 1ns/1ns
module tb_alu_exec_asserts (
	input logic                       clk,
	input logic                       rst_n,
	input logic                       op_valid,
	input alu_pkg::alu_op_e           op_code,
	input logic [alu_pkg::DATA_W-1:0] op_a,
	input logic [alu_pkg::DATA_W-1:0] op_b,
	input logic                       res_credit,
	input logic                       op_credit,
	input logic                       res_valid,
	input logic [alu_pkg::DATA_W-1:0] res_data,
	input logic                       res_c, res_z, res_gt, res_v, res_n
);
	import alu_pkg::*;

	int                err_cnt = 0; // read by the testbench
	logic [DATA_W+4:0] exp_q;       // {res, n, v, gt, z, c} of the op in flight
	logic [DATA_W-1:0] exp_res;
	logic [4:0]        exp_f, got_f;
	logic              busy_q;      // op accepted, result not out yet
	logic [15:0]       lat_q, min_lat_q;
	logic [CREDIT_W:0] granted_q;   // slots granted and not yet used
	string             flag_names [5] = '{"res_c", "res_z", "res_gt", "res_v", "res_n"};

	// expected result and flags straight from the op definitions
	function automatic logic [DATA_W+4:0] model_op(alu_op_e op, logic [DATA_W-1:0] a, b);
		logic [2*DATA_W-1:0] p;
		logic [DATA_W-1:0]   r;
		logic                c, gt, v, arith;
		p = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b}; // full product
		{c, gt, v} = 3'b000;
		arith = (op == OP_ADD) || (op == OP_SUB) || (op == OP_MUL);
		case (op)
			OP_ADD: {c, r} = a + b;
			OP_SUB: begin
				r = a - b;
				c = (a >= b); // no borrow
			end
			OP_XOR: r = a ^ b;
			OP_SLT: r = DATA_W'(a < b);
			OP_SLL: r = a << b[SHAMT_W-1:0];
			OP_SRL: r = a >> b[SHAMT_W-1:0];
			OP_MUL: begin
				r = p[DATA_W-1:0];
				c = |p[2*DATA_W-1:DATA_W]; // does not fit one word
				v = c;
			end
			default: r = '0;
		endcase
		// sign of a changed although the operand signs said it could not
		if (op == OP_ADD || op == OP_SUB)
			v = (a[DATA_W-1] != r[DATA_W-1]) && ((a[DATA_W-1] == b[DATA_W-1]) == (op == OP_ADD));
		gt = (op == OP_SUB) && !r[DATA_W-1] && !v && (r != '0);
		return {r, arith & r[DATA_W-1], v, gt, arith & (r == '0), c};
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q    <= 1'b0;
			granted_q <= '0; // reset drops every granted slot
			lat_q     <= '0;
			min_lat_q <= '0;
			exp_q     <= '0;
		end else begin
			granted_q <= granted_q + res_credit - res_valid;
			lat_q     <= lat_q + 1'b1;
			if (op_valid) begin
				busy_q    <= 1'b1;
				lat_q     <= '0;
				exp_q     <= model_op(op_code, op_a, op_b);
				min_lat_q <= (op_code == OP_MUL) ? 16'(MUL_STEPS + 1) : 16'd1;
			end else if (res_valid) begin
				busy_q <= 1'b0; // one result per op
			end
		end
	end

	assign exp_res = exp_q[DATA_W+4:5];
	assign exp_f   = exp_q[4:0];
	assign got_f   = {res_n, res_v, res_gt, res_z, res_c};

	property match(got, exp);
		@(posedge clk) disable iff (!rst_n) res_valid |-> got == exp;
	endproperty

	a_data: assert property (match(res_data, exp_res)) else begin
		err_cnt++;
		$error("Mismatch res_data exp %h got %h", $sampled(exp_res), $sampled(res_data));
	end

	for (genvar i = 0; i < 5; i++) begin : g_flag
		a_flag: assert property (match(got_f[i], exp_f[i])) else begin
			err_cnt++;
			$error("Mismatch %s exp %h got %h", flag_names[i], $sampled(exp_f[i]), $sampled(got_f[i]));
		end
	end

	a_credit: assert property (@(posedge clk) disable iff (!rst_n) res_valid |-> granted_q != '0)
	else begin
		err_cnt++;
		$error("result sent without credit");
	end

	a_pair: assert property (@(posedge clk) disable iff (!rst_n) op_credit == res_valid) else begin
		err_cnt++;
		$error("op credit and result valid not returned together");
	end

	a_once: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> busy_q && lat_q >= min_lat_q) else begin
		err_cnt++;
		$error("result without a pending op or earlier than its minimum latency");
	end

endmodule

bind alu_exec_top tb_alu_exec_asserts u_chk (.*);

/* testbench/tb_alu_exec.sv */
`timescale 1ns/1ns
module tb_alu_exec;
	import alu_pkg::*;

	localparam int RST_CYC = 10;
	localparam int N_OPS   = 16; // ops per test
	localparam int N_TESTS = 5;
	// each op fits in MUL_STEPS+8 cycles plus power-on and mid-run reset
	localparam int CYC_LIMIT = N_TESTS * N_OPS * (MUL_STEPS + 8) + 2 * RST_CYC;

	logic              clk, por_n, soft_rst_n, rst_n;
	logic              op_valid, res_credit;
	alu_op_e           op_code;
	logic [DATA_W-1:0] op_a, op_b, res_data;
	logic              op_credit, res_valid, res_c, res_z, res_gt, res_v, res_n;
	logic [31:0]       rnd = 32'hf20;
	logic [DATA_W-1:0] corner [6] = '{24'h000000, 24'h000001, 24'h7fffff, 24'h800000,
		24'hffffff, 24'h00001f};
	int                cyc = 0;
	int                n_pass = 0;
	int                n_fail = 0;

	assign rst_n = por_n & soft_rst_n;

	tb_clkgen u_clk (.clk(clk), .rst_n(por_n));

	alu_exec_top i_dut (.*);

	// xorshift32 step whose low bits give the operand
	function automatic logic [DATA_W-1:0] next_word();
		rnd ^= rnd << 13;
		rnd ^= rnd >> 17;
		rnd ^= rnd << 5;
		return rnd[DATA_W-1:0];
	endfunction

	// one op with its result slot granted after hold cycles
	task automatic send_op(alu_op_e op, logic [DATA_W-1:0] a, b, int hold);
		@(negedge clk);
		op_valid = 1'b1; // spends our single op credit
		op_code  = op;
		op_a     = a;
		op_b     = b;
		@(negedge clk);
		op_valid = 1'b0;
		repeat (hold) @(negedge clk); // result must stay back meanwhile
		res_credit = 1'b1;
		@(negedge clk);
		res_credit = 1'b0;
		while (!op_credit) @(negedge clk); // op credit back with the result
	endtask

	task automatic run_test(string name, int kind);
		alu_op_e           ops [5] = '{OP_XOR, OP_SLT, OP_SLL, OP_SRL, OP_NOP};
		logic [DATA_W-1:0] a, b;
		alu_op_e           op;
		int                errs;
		errs = i_dut.u_chk.err_cnt;
		if (kind == 4) begin
			res_credit = 1'b1; // two slots that the reset drops
			repeat (2) @(negedge clk);
			res_credit = 1'b0;
			soft_rst_n = 1'b0;
			repeat (RST_CYC) @(negedge clk);
			soft_rst_n = 1'b1;
		end
		for (int i = 0; i < N_OPS; i++) begin
			a = next_word();
			b = next_word(); // upper bits set but shifts use only the low five
			case (kind)
				0: begin
					op = (i % 2) ? OP_SUB : OP_ADD;
					if (i < 6) begin
						a = corner[i];
						b = (i % 2) ? a : 24'h1; // equal on sub and +1 on add
					end
				end
				1: op = ops[i % 5];
				2: begin
					op = OP_MUL;
					if (i < 6) a = corner[i];
				end
				default: op = alu_op_e'(a[2:0] ^ b[5:3]); // any code
			endcase
			send_op(op, a, b, (kind >= 3) ? 3 + i % 5 : i % 3);
		end
		repeat (2) @(negedge clk); // last result still being checked
		errs = i_dut.u_chk.err_cnt - errs;
		$display("test %s: %0d ops, %0d errors", name, N_OPS, errs);
		if (errs == 0)
			n_pass++;
		else
			n_fail++;
	endtask

	// run limit
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= CYC_LIMIT) begin
			$display("timeout after %0d cycles, the DUT stopped returning results", cyc);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		op_valid   = 1'b0;
		res_credit = 1'b0;
		op_code    = OP_NOP;
		op_a       = '0;
		op_b       = '0;
		soft_rst_n = 1'b1;
		@(posedge por_n);
		repeat (4) @(negedge clk); // idle with nothing coming out
		run_test("add_sub", 0);
		run_test("logic_shift", 1);
		run_test("multiply", 2);
		run_test("backpressure", 3);
		run_test("mid_reset", 4);
		$display("tests passed %0d failed %0d", n_pass, n_fail);
		if (n_fail == 0 && i_dut.u_chk.err_cnt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* flist.f */
source/alu_pkg.sv
source/adder.sv
source/multiplicator.sv
source/step_counter.sv
source/alu.sv
source/alu_ctrl_fsm.sv
source/alu_exec_top.sv
testbench/tb_clkgen.sv
testbench/tb_alu_exec_asserts.sv
testbench/tb_alu_exec.sv

/* Bender.yml */
package:
  name: alu_exec

sources:
  - source/alu_pkg.sv
  - source/adder.sv
  - source/multiplicator.sv
  - source/step_counter.sv
  - source/alu.sv
  - source/alu_ctrl_fsm.sv
  - source/alu_exec_top.sv
  - target: test
    files:
      - testbench/tb_clkgen.sv
      - testbench/tb_alu_exec_asserts.sv
      - testbench/tb_alu_exec.sv
